// File: logic/vid_pkg.sv
package vid_pkg;

  // --------------------------------------------------
  // active picture size and field widths
  // --------------------------------------------------
  localparam int active_w = 16;
  localparam int active_h = 8;

  localparam int x_w   = 5;
  localparam int y_w   = 4;
  localparam int pix_w = 8;

  // last usable position on each axis
  localparam logic [x_w-1:0] x_last = x_w'(active_w - 1);
  localparam logic [y_w-1:0] y_last = y_w'(active_h - 1);

  // counter value once an axis has run off the active area
  localparam logic [x_w-1:0] x_end = x_w'(active_w);
  localparam logic [y_w-1:0] y_end = y_w'(active_h);

  // raw stream sample
  typedef struct packed {
    logic             de;
    logic             vs;
    logic [pix_w-1:0] pix;
  } vid_in_t;

  // edge events, aligned with the pixel they belong to
  typedef struct packed {
    logic             pix_valid;
    logic             frame_start;
    logic             line_start;
    logic             line_end;
    logic [pix_w-1:0] pix;
  } vid_ev_t;

  typedef struct packed {
    logic [x_w-1:0] x;
    logic [y_w-1:0] y;
    logic           overflow;
  } pos_t;

endpackage

// File: logic/wb_pkg.sv
package wb_pkg;

  import vid_pkg::*;

  localparam int wb_aw = 3;
  localparam int wb_dw = 32;

  // --------------------------------------------------
  // register map
  // --------------------------------------------------
  localparam logic [wb_aw-1:0] reg_ctrl   = 3'd0;
  localparam logic [wb_aw-1:0] reg_status = 3'd1;
  localparam logic [wb_aw-1:0] reg_roi_x  = 3'd2;
  localparam logic [wb_aw-1:0] reg_roi_y  = 3'd3;
  localparam logic [wb_aw-1:0] reg_sum    = 3'd4;
  localparam logic [wb_aw-1:0] reg_count  = 3'd5;

  typedef struct packed {
    logic             cyc;
    logic             stb;
    logic             we;
    logic [wb_aw-1:0] adr;
    logic [wb_dw-1:0] dat_w;
  } wb_req_t;

  typedef struct packed {
    logic             ack;
    logic [wb_dw-1:0] dat_r;
  } wb_rsp_t;

  typedef enum logic [1:0] {
    cap_idle    = 2'd0,
    cap_armed   = 2'd1,
    cap_capture = 2'd2,
    cap_done    = 2'd3
  } cap_state_t;

  // inclusive region of interest bounds
  typedef struct packed {
    logic [x_w-1:0] x0;
    logic [x_w-1:0] x1;
    logic [y_w-1:0] y0;
    logic [y_w-1:0] y1;
  } roi_t;

endpackage

// File: logic/sync_edge_detect.sv
module sync_edge_detect
  import vid_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  vid_in_t vid,
  output vid_ev_t ev
);

  // two stages of the control bits, one of the pixel
  logic             de_q;
  logic             de_qq;
  logic             vs_q;
  logic             vs_qq;
  logic [pix_w-1:0] pix_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      de_q  <= 1'b0;
      de_qq <= 1'b0;
      vs_q  <= 1'b0;
      vs_qq <= 1'b0;
    end else begin
      de_q  <= vid.de;
      de_qq <= de_q;
      vs_q  <= vid.vs;
      vs_qq <= vs_q;
    end
  end

  always_ff @(posedge clk) begin
    pix_q <= vid.pix;
  end

  // edges are taken between the newest and the older sample
  assign ev.pix_valid   = de_q;
  assign ev.line_start  = de_q & ~de_qq;
  assign ev.line_end    = ~de_q & de_qq;
  assign ev.frame_start = vs_q & ~vs_qq;
  assign ev.pix         = pix_q;

endmodule

// File: logic/xy_counter.sv
module xy_counter
  import vid_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  vid_ev_t ev,
  output pos_t    pos
);

  // x holds the index of the next pixel, y the current line.
  // both stop one past the last position so an overrun stays visible
  logic [x_w-1:0] x_q;
  logic [y_w-1:0] y_q;
  logic           line_active;
  logic           cut_pending;
  logic           end_counted;

  // a line end left over from a line cut by a frame start is dropped
  assign end_counted = ev.line_end && !cut_pending && !ev.frame_start;

  // --------------------------------------------------
  // position of the pixel in this cycle
  // --------------------------------------------------
  always_comb begin
    if (ev.line_start) begin
      pos.x = '0;
    end else if (x_q == x_end) begin
      pos.x = x_last;
    end else begin
      pos.x = x_q;
    end

    pos.y = (y_q == y_end) ? y_last : y_q;

    pos.overflow = (ev.pix_valid && !ev.line_start && (x_q == x_end)) ||
                   (end_counted && (y_q == y_end));
  end

  // --------------------------------------------------
  // axis registers
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      x_q <= '0;
    end else if (ev.line_start) begin
      // first pixel sits at 0, the next one at 1
      x_q <= x_w'(1);
    end else if (ev.frame_start) begin
      x_q <= '0;
    end else if (ev.pix_valid && (x_q != x_end)) begin
      x_q <= x_q + x_w'(1);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      y_q <= '0;
    end else if (ev.frame_start) begin
      y_q <= '0;
    end else if (end_counted && (y_q != y_end)) begin
      y_q <= y_q + y_w'(1);
    end
  end

  // --------------------------------------------------
  // mid-line frame start tracking
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      line_active <= 1'b0;
    end else if (ev.line_start) begin
      line_active <= 1'b1;
    end else if (ev.line_end) begin
      line_active <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      cut_pending <= 1'b0;
    end else if (ev.frame_start) begin
      // line still running, so its end belongs to the old frame
      cut_pending <= line_active && !ev.line_end;
    end else if (ev.line_end || ev.line_start) begin
      cut_pending <= 1'b0;
    end
  end

endmodule

// File: logic/capture_fsm.sv
module capture_fsm
  import vid_pkg::*;
  import wb_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       arm,
  input  vid_ev_t    ev,
  input  pos_t       pos,
  output logic       clr,
  output logic       en,
  output cap_state_t state,
  output logic       frame_err
);

  cap_state_t state_n;

  always_comb begin
    state_n = state;
    case (state)
      cap_idle, cap_done: begin
        if (arm) state_n = cap_armed;
      end
      cap_armed: begin
        if (ev.frame_start) state_n = cap_capture;
      end
      cap_capture: begin
        if (ev.frame_start) state_n = cap_done;
      end
      default: state_n = cap_idle;
    endcase
  end

  // clear and first accumulation share the frame start cycle
  assign clr = (state == cap_armed) && ev.frame_start;
  assign en  = clr || ((state == cap_capture) && !ev.frame_start);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= cap_idle;
    end else begin
      state <= state_n;
    end
  end

  // sticky for the captured frame, cleared when the next capture starts
  always_ff @(posedge clk) begin
    if (rst) begin
      frame_err <= 1'b0;
    end else if (clr) begin
      // the frame start pixel already belongs to the new capture
      frame_err <= pos.overflow;
    end else if (en && pos.overflow) begin
      frame_err <= 1'b1;
    end
  end

endmodule

// File: logic/roi_accumulator.sv
module roi_accumulator
  import vid_pkg::*;
  import wb_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        clr,
  input  logic        en,
  input  vid_ev_t     ev,
  input  pos_t        pos,
  input  roi_t        roi,
  output logic [31:0] sum,
  output logic [15:0] count
);

  logic in_x;
  logic in_y;
  logic hit;

  // bounds are inclusive on both ends
  assign in_x = (pos.x >= roi.x0) && (pos.x <= roi.x1);
  assign in_y = (pos.y >= roi.y0) && (pos.y <= roi.y1);
  assign hit  = en && ev.pix_valid && in_x && in_y;

  always_ff @(posedge clk) begin
    if (rst) begin
      sum   <= '0;
      count <= '0;
    end else if (clr) begin
      // restart from this pixel
      sum   <= hit ? 32'(ev.pix) : 32'd0;
      count <= hit ? 16'd1 : 16'd0;
    end else if (hit) begin
      sum   <= sum + 32'(ev.pix);
      count <= count + 16'd1;
    end
  end

endmodule

// File: logic/wb_regs.sv
module wb_regs
  import vid_pkg::*;
  import wb_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  wb_req_t     wb_req,
  output wb_rsp_t     wb_rsp,
  output roi_t        roi,
  output logic        arm,
  input  cap_state_t  state,
  input  logic        frame_err,
  input  logic [31:0] sum,
  input  logic [15:0] count
);

  logic             ack_q;
  logic [wb_dw-1:0] dat_q;
  logic [wb_dw-1:0] rd_data;
  logic             access;
  logic             wr;

  // one access per strobe, the cycle with ack high is ignored
  assign access = wb_req.cyc && wb_req.stb && !ack_q;
  assign wr     = access && wb_req.we;

  // --------------------------------------------------
  // read mux
  // --------------------------------------------------
  always_comb begin
    case (wb_req.adr)
      reg_status: rd_data = {29'd0, frame_err, state};
      reg_roi_x:  rd_data = {11'd0, roi.x1, 11'd0, roi.x0};
      reg_roi_y:  rd_data = {12'd0, roi.y1, 12'd0, roi.y0};
      reg_sum:    rd_data = sum;
      reg_count:  rd_data = {16'd0, count};
      default:    rd_data = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ack_q <= 1'b0;
      arm   <= 1'b0;
    end else begin
      ack_q <= access;
      arm   <= wr && (wb_req.adr == reg_ctrl) && wb_req.dat_w[0];
    end
  end

  // read data goes out together with ack
  always_ff @(posedge clk) begin
    if (access) begin
      dat_q <= rd_data;
    end
  end

  // --------------------------------------------------
  // region of interest, full area after reset
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      roi.x0 <= '0;
      roi.x1 <= x_last;
      roi.y0 <= '0;
      roi.y1 <= y_last;
    end else if (wr && (wb_req.adr == reg_roi_x)) begin
      roi.x0 <= wb_req.dat_w[x_w-1:0];
      roi.x1 <= wb_req.dat_w[16+x_w-1:16];
    end else if (wr && (wb_req.adr == reg_roi_y)) begin
      roi.y0 <= wb_req.dat_w[y_w-1:0];
      roi.y1 <= wb_req.dat_w[16+y_w-1:16];
    end
  end

  assign wb_rsp.ack   = ack_q;
  assign wb_rsp.dat_r = dat_q;

endmodule

// File: logic/frame_probe_top.sv
module frame_probe_top
  import vid_pkg::*;
  import wb_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  vid_in_t vid,
  input  wb_req_t wb_req,
  output wb_rsp_t wb_rsp
);

  vid_ev_t     ev;
  pos_t        pos;
  roi_t        roi;
  cap_state_t  state;
  logic        arm;
  logic        clr;
  logic        en;
  logic        frame_err;
  logic [31:0] sum;
  logic [15:0] count;

  // stream path
  sync_edge_detect u_sync (.clk(clk), .rst(rst), .vid(vid), .ev(ev));

  xy_counter u_xy (.clk(clk), .rst(rst), .ev(ev), .pos(pos));

  capture_fsm u_fsm (
    .clk(clk), .rst(rst), .arm(arm), .ev(ev), .pos(pos),
    .clr(clr), .en(en), .state(state), .frame_err(frame_err)
  );

  roi_accumulator u_acc (
    .clk(clk), .rst(rst), .clr(clr), .en(en), .ev(ev), .pos(pos),
    .roi(roi), .sum(sum), .count(count)
  );

  // host side
  wb_regs u_regs (
    .clk(clk), .rst(rst), .wb_req(wb_req), .wb_rsp(wb_rsp), .roi(roi),
    .arm(arm), .state(state), .frame_err(frame_err), .sum(sum), .count(count)
  );

endmodule

// File: tests/tb_frame_probe.sv
module tb_frame_probe
  import vid_pkg::*;
  import wb_pkg::*;
;

  localparam int ack_limit  = 20;
  localparam int done_limit = 50;

  logic    clk;
  logic    rst;
  vid_in_t vid;
  wb_req_t wb_req;
  wb_rsp_t wb_rsp;

  // --------------------------------------------------
  // reference model state
  // --------------------------------------------------
  logic        m_pde;
  logic        m_pvs;
  int          m_col;
  int          m_row;
  logic        m_lact;
  logic        m_cut;
  logic        m_armed;
  logic        m_on;
  logic [31:0] m_sum;
  logic [15:0] m_cnt;
  logic        m_err;
  int          rx0;
  int          rx1;
  int          ry0;
  int          ry1;

  frame_probe_top u_dut (.clk(clk), .rst(rst), .vid(vid), .wb_req(wb_req), .wb_rsp(wb_rsp));

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("Error: %s is 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  // follows one input sample with the position and capture rules
  task automatic model_step(input logic de, input logic vs, input logic [pix_w-1:0] pix);
    logic ls;
    logic le;
    logic fs;
    logic counted;
    logic ov;
    int   px;
    int   py;
    ls = de && !m_pde;
    le = !de && m_pde;
    fs = vs && !m_pvs;
    counted = le && !m_cut && !fs;
    px = ls ? 0 : ((m_col >= active_w) ? active_w - 1 : m_col);
    py = (m_row >= active_h) ? active_h - 1 : m_row;
    ov = (de && !ls && m_col >= active_w) || (counted && m_row >= active_h);
    if (fs && m_armed) begin
      m_armed = 1'b0;
      m_on    = 1'b1;
      m_sum   = '0;
      m_cnt   = '0;
      m_err   = 1'b0;
    end else if (fs) begin
      m_on = 1'b0;
    end
    if (m_on && de && px >= rx0 && px <= rx1 && py >= ry0 && py <= ry1) begin
      m_sum = m_sum + 32'(pix);
      m_cnt = m_cnt + 16'd1;
    end
    if (m_on && ov) m_err = 1'b1;
    // next pixel index and line index
    if (ls) m_col = 1;
    else if (fs) m_col = 0;
    else if (de && m_col < active_w) m_col = m_col + 1;
    if (fs) m_row = 0;
    else if (counted && m_row < active_h) m_row = m_row + 1;
    if (fs) m_cut = m_lact && !le;
    else if (le || ls) m_cut = 1'b0;
    if (ls) m_lact = 1'b1;
    else if (le) m_lact = 1'b0;
    m_pde = de;
    m_pvs = vs;
  endtask

  // --------------------------------------------------
  // stream generation
  // --------------------------------------------------
  task automatic put(input logic de, input logic vs, input logic [pix_w-1:0] pix);
    @(posedge clk);
    #2;
    vid.de  = de;
    vid.vs  = vs;
    vid.pix = pix;
    model_step(de, vs, pix);
  endtask

  task automatic idle(input int n);
    repeat (n) put(1'b0, 1'b0, '0);
  endtask

  task automatic vs_pulse();
    put(1'b0, 1'b1, '0);
    put(1'b0, 1'b1, '0);
    idle(2);
  endtask

  // vs_at below zero means no vs inside the line
  task automatic send_line(input int len, input int vs_at);
    logic vs;
    for (int i = 0; i < len; i++) begin
      vs = (vs_at >= 0) && (i >= vs_at) && (i < vs_at + 2);
      put(1'b1, vs, pix_w'($urandom_range(0, 255)));
    end
    idle($urandom_range(1, 3));
  endtask

  // kind 0 clean, 1 overlong line, 2 extra line, 3 vs in the middle of a line
  task automatic send_frame(input int kind);
    int n_lines;
    int len;
    n_lines = (kind == 2) ? active_h + 1 : active_h;
    if (kind == 3) begin
      send_line(active_w, $urandom_range(3, active_w - 4));
    end else begin
      vs_pulse();
    end
    idle($urandom_range(2, 5));
    for (int l = 0; l < n_lines; l++) begin
      len = (kind == 1 && l == 3) ? active_w + 3 : active_w;
      send_line(len, -1);
    end
  endtask

  // --------------------------------------------------
  // Wishbone host
  // --------------------------------------------------
  task automatic wb_access(input logic we, input logic [wb_aw-1:0] adr,
                           input logic [31:0] wdat, output logic [31:0] rdat);
    @(posedge clk);
    #2;
    // ack of the previous access lasts a single cycle
    check("wb_rsp.ack", {31'd0, wb_rsp.ack}, 32'd0);
    wb_req.cyc   = 1'b1;
    wb_req.stb   = 1'b1;
    wb_req.we    = we;
    wb_req.adr   = adr;
    wb_req.dat_w = wdat;
    for (int t = 0; t < ack_limit; t++) begin
      @(posedge clk);
      #2;
      if (wb_rsp.ack) break;
    end
    if (!wb_rsp.ack) abort_run("no Wishbone ack arrived in time");
    rdat = wb_rsp.dat_r;
    wb_req.cyc = 1'b0;
    wb_req.stb = 1'b0;
    wb_req.we  = 1'b0;
  endtask

  task automatic wb_write(input logic [wb_aw-1:0] adr, input logic [31:0] wdat);
    logic [31:0] unused;
    wb_access(1'b1, adr, wdat, unused);
  endtask

  task automatic wb_read(input logic [wb_aw-1:0] adr, output logic [31:0] rdat);
    wb_access(1'b0, adr, '0, rdat);
  endtask

  task automatic wait_done();
    logic [31:0] st;
    st = '0;
    for (int t = 0; t < done_limit; t++) begin
      wb_read(reg_status, st);
      if (st[1:0] == cap_done) break;
    end
    if (st[1:0] != cap_done) abort_run("capture never reached the done state");
  endtask

  task automatic set_roi(input int x0, input int x1, input int y0, input int y1);
    logic [31:0] xw;
    logic [31:0] yw;
    logic [31:0] rd;
    rx0 = x0;
    rx1 = x1;
    ry0 = y0;
    ry1 = y1;
    xw = (32'(x1) << 16) | 32'(x0);
    yw = (32'(y1) << 16) | 32'(y0);
    wb_write(reg_roi_x, xw);
    wb_write(reg_roi_y, yw);
    wb_read(reg_roi_x, rd);
    check("reg_roi_x", rd, xw);
    wb_read(reg_roi_y, rd);
    check("reg_roi_y", rd, yw);
  endtask

  // arm, send one frame, close it with the next vs and compare results
  task automatic run_capture(input int kind, output logic [31:0] st);
    logic [31:0] rd;
    m_armed = 1'b1;
    wb_write(reg_ctrl, 32'd1);
    wb_read(reg_status, rd);
    check("reg_status", rd, {29'd0, m_err, cap_armed});
    send_frame(kind);
    vs_pulse();
    wait_done();
    wb_read(reg_sum, rd);
    check("reg_sum", rd, m_sum);
    wb_read(reg_count, rd);
    check("reg_count", rd, {16'd0, m_cnt});
    wb_read(reg_status, st);
    check("reg_status", st, {29'd0, m_err, cap_done});
  endtask

  initial begin
    logic [31:0] rd;
    int          x0;
    int          y0;
    void'($urandom(32'h205c));
    rst    = 1'b1;
    vid    = '0;
    wb_req = '0;
    m_pde = 1'b0;
    m_pvs = 1'b0;
    m_col = 0;
    m_row = 0;
    m_lact = 1'b0;
    m_cut = 1'b0;
    m_armed = 1'b0;
    m_on = 1'b0;
    m_sum = '0;
    m_cnt = '0;
    m_err = 1'b0;
    rx0 = 0;
    rx1 = active_w - 1;
    ry0 = 0;
    ry1 = active_h - 1;
    repeat (4) @(posedge clk);
    #2;
    rst = 1'b0;

    // values after reset
    wb_read(reg_status, rd);
    check("reg_status", rd, 32'd0);
    wb_read(reg_sum, rd);
    check("reg_sum", rd, 32'd0);
    wb_read(reg_count, rd);
    check("reg_count", rd, 32'd0);
    wb_read(reg_roi_x, rd);
    check("reg_roi_x", rd, 32'(active_w - 1) << 16);
    wb_read(reg_roi_y, rd);
    check("reg_roi_y", rd, 32'(active_h - 1) << 16);

    // full area, clean frame
    run_capture(0, rd);
    wb_read(reg_count, rd);
    check("reg_count", rd, 32'(active_w * active_h));

    // unmapped addresses read as zero
    wb_read(3'd7, rd);
    check("wb_rsp.dat_r", rd, 32'd0);

    // random regions, then a single pixel and a single line
    repeat (6) begin
      x0 = $urandom_range(0, active_w - 1);
      y0 = $urandom_range(0, active_h - 1);
      set_roi(x0, $urandom_range(x0, active_w - 1), y0, $urandom_range(y0, active_h - 1));
      run_capture(0, rd);
    end
    x0 = $urandom_range(0, active_w - 1);
    y0 = $urandom_range(0, active_h - 1);
    set_roi(x0, x0, y0, y0);
    run_capture(0, rd);
    set_roi(0, active_w - 1, y0, y0);
    run_capture(0, rd);

    // overruns raise the error, a clean frame clears it
    set_roi(active_w - 6, active_w - 1, 2, active_h - 1);
    run_capture(1, rd);
    check("frame_err", {31'd0, rd[2]}, 32'd1);
    run_capture(2, rd);
    check("frame_err", {31'd0, rd[2]}, 32'd1);
    run_capture(0, rd);
    check("frame_err", {31'd0, rd[2]}, 32'd0);

    // frame start cutting an active line
    set_roi(0, active_w - 1, 0, active_h - 1);
    run_capture(3, rd);
    check("frame_err", {31'd0, rd[2]}, 32'd0);
    set_roi(2, active_w - 3, active_h - 2, active_h - 1);
    run_capture(3, rd);

    $display("All tests passed");
    $finish;
  end

endmodule

// File: src.f
logic/vid_pkg.sv
logic/wb_pkg.sv
logic/sync_edge_detect.sv
logic/xy_counter.sv
logic/capture_fsm.sv
logic/roi_accumulator.sv
logic/wb_regs.sv
logic/frame_probe_top.sv
tests/tb_frame_probe.sv

// File: Makefile
TOP = tb_frame_probe

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module frame_probe_top -f src.f
	verilator --lint-only --timing --top-module $(TOP) -f src.f

sim:
	verilator --binary -j 0 --top-module $(TOP) -Mdir obj_dir -f src.f
	-./obj_dir/V$(TOP) > sim.log 2>&1
	cat sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
